//--- Makefile
# Verilator simulation of the Wishbone subsystem
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_wb_subsys
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# The run may exit non-zero, the log decides the result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/wb_pkg.sv
//********************************************************************
// Wishbone subsystem package with bus word types and the enums for
// target selection and decoder state
//********************************************************************

`include "wb_settings.svh"

package wb_pkg;

	// Bus words
	typedef logic [`WB_ADDR_WIDTH-1:0] wb_addr_t;
	typedef logic [`WB_DATA_WIDTH-1:0] wb_data_t;
	typedef logic [`WB_SEL_WIDTH-1:0] wb_sel_t;

	// Decoded target, TGT_NONE marks an unmapped address
	typedef enum logic [1:0] {
		TGT_S0 = 2'd0,
		TGT_S1 = 2'd1,
		TGT_S2 = 2'd2,
		TGT_NONE = 2'd3
	} target_e;

	// Request decoder states
	typedef enum logic {
		DEC_IDLE = 1'b0,
		DEC_ACTIVE = 1'b1
	} dec_state_e;

endpackage

//--- hw/wb_ram_target.sv
//********************************************************************
// Wishbone RAM target with byte-select writes, registered read data
// and a one-cycle acknowledge
//********************************************************************

`timescale 1ns/1ns
`include "wb_settings.svh"

module wb_ram_target (
	input logic clk,
	input logic rstn,
	input logic cyc_i,
	input logic stb_i,
	input logic we_i,
	// Word index within this target
	input logic [`WB_RAM_AW-1:0] adr_i,
	input wb_pkg::wb_sel_t sel_i,
	input wb_pkg::wb_data_t dat_i,
	output wb_pkg::wb_data_t dat_o,
	output logic ack_o
);
	import wb_pkg::*;

	// Storage
	wb_data_t mem [`WB_RAM_WORDS];

	wb_data_t rd_q;
	logic ack_q;
	// Set once a strobe is served, cleared when STB drops
	logic done_q;
	logic req;

	// New request only once per STB assertion
	assign req = cyc_i && stb_i && !done_q;

	// Write enabled lanes, or capture read data
	always_ff @(posedge clk) begin
		if (req) begin
			if (we_i) begin
				for (int b = 0; b < `WB_SEL_WIDTH; b++) begin
					if (sel_i[b]) begin
						mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8];
					end
				end
			end else begin
				rd_q <= mem[adr_i];
			end
		end
	end

	// Acknowledge one cycle after the strobe is sampled
	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			ack_q <= req;
			if (!stb_i) begin
				done_q <= 1'b0;
			end else if (req) begin
				done_q <= 1'b1;
			end
		end
	end

	assign dat_o = rd_q;
	assign ack_o = ack_q;

endmodule

//--- hw/wb_req_decoder.sv
//********************************************************************
// Master-side request decoder that latches the addressed target and
// routes CYC and STB to it
//********************************************************************

`timescale 1ns/1ns
`include "wb_settings.svh"

module wb_req_decoder (
	input logic clk,
	input logic rstn,
	// Master request
	input logic m_cyc_i,
	input logic m_stb_i,
	input logic m_we_i,
	input wb_pkg::wb_addr_t m_adr_i,
	input wb_pkg::wb_sel_t m_sel_i,
	input wb_pkg::wb_data_t m_dat_i,
	// Completion, seen from the response mux
	input logic m_ack_i,
	input logic m_err_i,
	// Target side
	output logic [`WB_N_TARGETS-1:0] s_cyc_o,
	output logic [`WB_N_TARGETS-1:0] s_stb_o,
	output logic [`WB_RAM_AW-1:0] s_adr_o,
	output logic s_we_o,
	output wb_pkg::wb_sel_t s_sel_o,
	output wb_pkg::wb_data_t s_dat_o,
	// Routing info for the response mux
	output wb_pkg::target_e sel_target_o,
	output logic active_o
);
	import wb_pkg::*;

	dec_state_e state_q;
	target_e sel_q;
	target_e hit;
	wb_addr_t win_base;
	wb_addr_t offset;

	// Windows are checked in order, first match wins
	function automatic target_e addr_decode(input wb_addr_t adr);
		if (adr >= `WB_S0_BASE && adr <= `WB_S0_LIMIT) begin
			return TGT_S0;
		end
		if (adr >= `WB_S1_BASE && adr <= `WB_S1_LIMIT) begin
			return TGT_S1;
		end
		if (adr >= `WB_S2_BASE && adr <= `WB_S2_LIMIT) begin
			return TGT_S2;
		end
		return TGT_NONE;
	endfunction

	assign hit = addr_decode(m_adr_i);

	// Latch the target on the first strobe, release on ACK or ERR
	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= DEC_IDLE;
			sel_q <= TGT_NONE;
		end else begin
			case (state_q)
				DEC_IDLE: begin
					if (m_cyc_i && m_stb_i) begin
						state_q <= DEC_ACTIVE;
						sel_q <= hit;
					end
				end
				DEC_ACTIVE: begin
					// Completion is visible for exactly one cycle
					if (m_ack_i || m_err_i) begin
						state_q <= DEC_IDLE;
						sel_q <= TGT_NONE;
					end
				end
			endcase
		end
	end

	// Base of the latched window
	always_comb begin
		case (sel_q)
			TGT_S1: win_base = `WB_S1_BASE;
			TGT_S2: win_base = `WB_S2_BASE;
			default: win_base = `WB_S0_BASE;
		endcase
	end

	// Word index within the window, targets never see the base
	assign offset = m_adr_i - win_base;
	assign s_adr_o = offset[`WB_RAM_AW+1:2];

	// Only the latched target gets CYC and STB
	always_comb begin
		s_cyc_o = '0;
		s_stb_o = '0;
		for (int i = 0; i < `WB_N_TARGETS; i++) begin
			if (state_q == DEC_ACTIVE && sel_q == target_e'(i)) begin
				s_cyc_o[i] = m_cyc_i;
				s_stb_o[i] = m_cyc_i && m_stb_i;
			end
		end
	end

	// Shared request fields go to every target
	assign s_we_o = m_we_i;
	assign s_sel_o = m_sel_i;
	assign s_dat_o = m_dat_i;

	assign sel_target_o = sel_q;
	assign active_o = (state_q == DEC_ACTIVE);

endmodule

//--- hw/wb_resp_mux.sv
//********************************************************************
// Response mux returning data and ACK from the selected target, with
// the decode-fail responder for unmapped addresses
//********************************************************************

`timescale 1ns/1ns
`include "wb_settings.svh"

module wb_resp_mux (
	input logic clk,
	input logic rstn,
	// Routing from the decoder
	input wb_pkg::target_e sel_target_i,
	input logic active_i,
	// Per-target responses
	input wb_pkg::wb_data_t [`WB_N_TARGETS-1:0] t_dat_i,
	input logic [`WB_N_TARGETS-1:0] t_ack_i,
	// Master response
	output wb_pkg::wb_data_t m_dat_o,
	output logic m_ack_o,
	output logic m_err_o
);
	import wb_pkg::*;

	// Decode-fail responder
	logic err_q;
	logic miss;

	// Active cycle with no target behind it
	assign miss = active_i && (sel_target_i == TGT_NONE);

	// Raises ERR one cycle after the miss is seen, never twice in a row
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= miss && !err_q;
		end
	end

	// Data and ACK from the latched target
	// Zero data when nothing is selected
	always_comb begin
		m_dat_o = '0;
		m_ack_o = 1'b0;
		for (int i = 0; i < `WB_N_TARGETS; i++) begin
			if (sel_target_i == target_e'(i)) begin
				m_dat_o = t_dat_i[i];
				m_ack_o = t_ack_i[i];
			end
		end
	end

	assign m_err_o = err_q;

endmodule

//--- hw/wb_subsys_top.sv
//********************************************************************
// Wishbone subsystem top with the request decoder, three RAM targets
// and the response mux
//********************************************************************

`timescale 1ns/1ns
`include "wb_settings.svh"

module wb_subsys_top (
	input logic clk,
	input logic rstn,
	// Master port
	input logic m_cyc_i,
	input logic m_stb_i,
	input logic m_we_i,
	input wb_pkg::wb_addr_t m_adr_i,
	input wb_pkg::wb_sel_t m_sel_i,
	input wb_pkg::wb_data_t m_dat_i,
	output wb_pkg::wb_data_t m_dat_o,
	output logic m_ack_o,
	output logic m_err_o
);
	import wb_pkg::*;

	// Decoder to targets
	logic [`WB_N_TARGETS-1:0] s_cyc;
	logic [`WB_N_TARGETS-1:0] s_stb;
	logic [`WB_RAM_AW-1:0] s_adr;
	logic s_we;
	wb_sel_t s_sel;
	wb_data_t s_dat;

	// Targets to mux
	wb_data_t [`WB_N_TARGETS-1:0] t_dat;
	logic [`WB_N_TARGETS-1:0] t_ack;

	// Decoder to mux
	target_e sel_target;
	logic active;

	// Request side, completion fed back from the mux
	wb_req_decoder u_dec (
		.clk (clk),
		.rstn (rstn),
		.m_cyc_i (m_cyc_i),
		.m_stb_i (m_stb_i),
		.m_we_i (m_we_i),
		.m_adr_i (m_adr_i),
		.m_sel_i (m_sel_i),
		.m_dat_i (m_dat_i),
		.m_ack_i (m_ack_o),
		.m_err_i (m_err_o),
		.s_cyc_o (s_cyc),
		.s_stb_o (s_stb),
		.s_adr_o (s_adr),
		.s_we_o (s_we),
		.s_sel_o (s_sel),
		.s_dat_o (s_dat),
		.sel_target_o (sel_target),
		.active_o (active)
	);

	// One RAM per window
	for (genvar i = 0; i < `WB_N_TARGETS; i++) begin : g_tgt
		wb_ram_target u_ram (
			.clk (clk),
			.rstn (rstn),
			.cyc_i (s_cyc[i]),
			.stb_i (s_stb[i]),
			.we_i (s_we),
			.adr_i (s_adr),
			.sel_i (s_sel),
			.dat_i (s_dat),
			.dat_o (t_dat[i]),
			.ack_o (t_ack[i])
		);
	end

	// Response side
	wb_resp_mux u_mux (
		.clk (clk),
		.rstn (rstn),
		.sel_target_i (sel_target),
		.active_i (active),
		.t_dat_i (t_dat),
		.t_ack_i (t_ack),
		.m_dat_o (m_dat_o),
		.m_ack_o (m_ack_o),
		.m_err_o (m_err_o)
	);

endmodule

//--- include/wb_settings.svh
//********************************************************************
// Bus widths, RAM depth and address windows for the Wishbone
// subsystem, shared by the package, the RTL and the testbench
//********************************************************************

`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// Master bus widths
`define WB_ADDR_WIDTH 32
`define WB_DATA_WIDTH 32
// One select bit per byte lane
`define WB_SEL_WIDTH (`WB_DATA_WIDTH/8)

// Depth of each RAM target and its word-index width
`define WB_RAM_WORDS 256
`define WB_RAM_AW 8

// Inclusive byte-address windows, one per target
`define WB_S0_BASE 32'h0000_0000
`define WB_S0_LIMIT 32'h0000_03FF
`define WB_S1_BASE 32'h0000_1000
`define WB_S1_LIMIT 32'h0000_13FF
`define WB_S2_BASE 32'h0000_2000
`define WB_S2_LIMIT 32'h0000_23FF

// Number of RAM targets behind the decoder
`define WB_N_TARGETS 3

`endif

//--- testbench/tb_wb_subsys.sv
//********************************************************************
// Testbench for the Wishbone subsystem with a stimulus table, a
// random write and read-back pass and typed compare tasks
//********************************************************************

`timescale 1ns/1ns
`include "wb_settings.svh"

module tb_wb_subsys;
	import wb_pkg::*;

	// Bus wait limit in clock cycles
	localparam int TIMEOUT_CYCLES = 20;
	// ACK or ERR comes in the second cycle after STB is first presented
	localparam int ACK_LATENCY = 2;

	// One table entry with its expected response
	typedef struct packed {
		logic we;
		wb_addr_t adr;
		wb_sel_t sel;
		wb_data_t wdat;
		wb_data_t exp_dat;
		logic exp_err;
		target_e exp_tgt;
	} row_t;

	logic clk;
	logic rstn;
	logic m_cyc_i;
	logic m_stb_i;
	logic m_we_i;
	wb_addr_t m_adr_i;
	wb_sel_t m_sel_i;
	wb_data_t m_dat_i;
	wb_data_t m_dat_o;
	logic m_ack_o;
	logic m_err_o;

	row_t table_q[$];
	// Model memory for the random pass indexed by target and word
	wb_data_t model [`WB_N_TARGETS][`WB_RAM_WORDS];
	integer seed;

	wb_subsys_top DUT (
		.clk (clk),
		.rstn (rstn),
		.m_cyc_i (m_cyc_i),
		.m_stb_i (m_stb_i),
		.m_we_i (m_we_i),
		.m_adr_i (m_adr_i),
		.m_sel_i (m_sel_i),
		.m_dat_i (m_dat_i),
		.m_dat_o (m_dat_o),
		.m_ack_o (m_ack_o),
		.m_err_o (m_err_o)
	);

	// 100 ns clock
	always #50 clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input wb_data_t exp, input wb_data_t act);
		if (act !== exp) begin
			abort_run($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
		end
	endtask

	task automatic check_target(input string name, input target_e exp, input target_e act);
		if (act !== exp) begin
			abort_run($sformatf("ERR %0t %s expected %s actual %s", $time, name,
				exp.name(), act.name()));
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			abort_run($sformatf("ERR %0t %s expected %0d actual %0d", $time, name, exp, act));
		end
	endtask

	// Enabled byte lanes take the new word
	function automatic wb_data_t merge_bytes(input wb_data_t old_w, input wb_data_t new_w,
			input wb_sel_t sel);
		wb_data_t res;
		res = old_w;
		for (int b = 0; b < `WB_SEL_WIDTH; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	function automatic wb_addr_t window_base(input int t);
		case (t)
			1: return `WB_S1_BASE;
			2: return `WB_S2_BASE;
			default: return `WB_S0_BASE;
		endcase
	endfunction

	// One classic transfer with the request held until ACK or ERR
	task automatic bus_xfer(input logic we, input wb_addr_t adr, input wb_sel_t sel,
			input wb_data_t wdat, output wb_data_t rdat, output logic ack,
			output logic err, output target_e tgt);
		int cnt;
		@(posedge clk);
		m_cyc_i <= 1'b1;
		m_stb_i <= 1'b1;
		m_we_i <= we;
		m_adr_i <= adr;
		m_sel_i <= sel;
		m_dat_i <= wdat;
		cnt = 0;
		// Responses are sampled mid-cycle
		@(negedge clk);
		while (!(m_ack_o || m_err_o) && cnt < TIMEOUT_CYCLES) begin
			cnt++;
			@(negedge clk);
		end
		if (!(m_ack_o || m_err_o)) begin
			abort_run($sformatf("Timeout waiting for ACK or ERR at address %h", adr));
		end
		check_count("response latency", ACK_LATENCY, cnt);
		rdat = m_dat_o;
		ack = m_ack_o;
		err = m_err_o;
		tgt = DUT.sel_target;
		@(posedge clk);
		m_cyc_i <= 1'b0;
		m_stb_i <= 1'b0;
		m_we_i <= 1'b0;
		// Completion lasts one cycle only
		@(negedge clk);
		check_flag("m_ack_o", 1'b0, m_ack_o);
		check_flag("m_err_o", 1'b0, m_err_o);
	endtask

	task automatic add_row(input logic we, input wb_addr_t adr, input wb_sel_t sel,
			input wb_data_t wdat, input wb_data_t exp_dat, input logic exp_err,
			input target_e exp_tgt);
		row_t r;
		r.we = we;
		r.adr = adr;
		r.sel = sel;
		r.wdat = wdat;
		r.exp_dat = exp_dat;
		r.exp_err = exp_err;
		r.exp_tgt = exp_tgt;
		table_q.push_back(r);
	endtask

	task automatic build_table();
		// Same offset in each window
		add_row(1'b1, 32'h0000_0000, 4'hF, 32'h1111_0000, '0, 1'b0, TGT_S0);
		add_row(1'b1, 32'h0000_1000, 4'hF, 32'h2222_0001, '0, 1'b0, TGT_S1);
		add_row(1'b1, 32'h0000_2000, 4'hF, 32'h3333_0002, '0, 1'b0, TGT_S2);
		add_row(1'b0, 32'h0000_0000, 4'hF, '0, 32'h1111_0000, 1'b0, TGT_S0);
		add_row(1'b0, 32'h0000_1000, 4'hF, '0, 32'h2222_0001, 1'b0, TGT_S1);
		add_row(1'b0, 32'h0000_2000, 4'hF, '0, 32'h3333_0002, 1'b0, TGT_S2);
		// Partial byte selects
		add_row(1'b1, 32'h0000_1000, 4'b0101, 32'hAABB_CCDD, '0, 1'b0, TGT_S1);
		add_row(1'b0, 32'h0000_1000, 4'hF, '0,
			merge_bytes(32'h2222_0001, 32'hAABB_CCDD, 4'b0101), 1'b0, TGT_S1);
		add_row(1'b1, 32'h0000_2000, 4'b1000, 32'h9900_0000, '0, 1'b0, TGT_S2);
		add_row(1'b0, 32'h0000_2000, 4'hF, '0,
			merge_bytes(32'h3333_0002, 32'h9900_0000, 4'b1000), 1'b0, TGT_S2);
		// Last word of each window
		add_row(1'b1, 32'h0000_03FC, 4'hF, 32'h0000_03FC, '0, 1'b0, TGT_S0);
		add_row(1'b1, 32'h0000_13FC, 4'hF, 32'h0000_13FC, '0, 1'b0, TGT_S1);
		add_row(1'b1, 32'h0000_23FC, 4'hF, 32'h0000_23FC, '0, 1'b0, TGT_S2);
		add_row(1'b0, 32'h0000_03FC, 4'hF, '0, 32'h0000_03FC, 1'b0, TGT_S0);
		add_row(1'b0, 32'h0000_13FC, 4'hF, '0, 32'h0000_13FC, 1'b0, TGT_S1);
		add_row(1'b0, 32'h0000_23FC, 4'hF, '0, 32'h0000_23FC, 1'b0, TGT_S2);
		// One word past a limit, gaps and top of the address space
		add_row(1'b0, 32'h0000_0400, 4'hF, '0, '0, 1'b1, TGT_NONE);
		add_row(1'b1, 32'h0000_1400, 4'hF, 32'hDEAD_BEEF, '0, 1'b1, TGT_NONE);
		add_row(1'b1, 32'h0000_2400, 4'hF, 32'hDEAD_BEEF, '0, 1'b1, TGT_NONE);
		add_row(1'b0, 32'h0000_0800, 4'hF, '0, '0, 1'b1, TGT_NONE);
		add_row(1'b1, 32'h0000_1800, 4'hF, 32'hDEAD_BEEF, '0, 1'b1, TGT_NONE);
		add_row(1'b0, 32'hFFFF_FFFC, 4'hF, '0, '0, 1'b1, TGT_NONE);
		// Failed writes map to word 0 offsets, which must be unchanged
		add_row(1'b0, 32'h0000_0000, 4'hF, '0, 32'h1111_0000, 1'b0, TGT_S0);
		add_row(1'b0, 32'h0000_1000, 4'hF, '0,
			merge_bytes(32'h2222_0001, 32'hAABB_CCDD, 4'b0101), 1'b0, TGT_S1);
		add_row(1'b0, 32'h0000_2000, 4'hF, '0,
			merge_bytes(32'h3333_0002, 32'h9900_0000, 4'b1000), 1'b0, TGT_S2);
	endtask

	task automatic apply_row(input row_t r, input int idx);
		wb_data_t rdat;
		logic ack;
		logic err;
		target_e tgt;
		bus_xfer(r.we, r.adr, r.sel, r.wdat, rdat, ack, err, tgt);
		check_target($sformatf("row %0d sel_target", idx), r.exp_tgt, tgt);
		check_flag($sformatf("row %0d m_err_o", idx), r.exp_err, err);
		check_flag($sformatf("row %0d m_ack_o", idx), !r.exp_err, ack);
		// Read data or zero data on any decode failure
		if (!r.we || r.exp_err) begin
			check_data($sformatf("row %0d m_dat_o", idx), r.exp_dat, rdat);
		end
	endtask

	// Random words into every word of every target, then read back
	task automatic random_pass();
		wb_data_t rdat;
		wb_data_t wdat;
		wb_addr_t adr;
		logic ack;
		logic err;
		target_e tgt;
		for (int w = 0; w < `WB_RAM_WORDS; w++) begin
			for (int t = 0; t < `WB_N_TARGETS; t++) begin
				adr = window_base(t) + wb_addr_t'(4 * w);
				wdat = $random(seed);
				model[t][w] = wdat;
				bus_xfer(1'b1, adr, 4'hF, wdat, rdat, ack, err, tgt);
				check_target("random write sel_target", target_e'(t), tgt);
				check_flag("random write m_err_o", 1'b0, err);
				check_flag("random write m_ack_o", 1'b1, ack);
			end
		end
		for (int t = 0; t < `WB_N_TARGETS; t++) begin
			for (int w = 0; w < `WB_RAM_WORDS; w++) begin
				adr = window_base(t) + wb_addr_t'(4 * w);
				bus_xfer(1'b0, adr, 4'hF, '0, rdat, ack, err, tgt);
				check_target("random read sel_target", target_e'(t), tgt);
				check_flag("random read m_err_o", 1'b0, err);
				check_flag("random read m_ack_o", 1'b1, ack);
				check_data($sformatf("m_dat_o at %h", adr), model[t][w], rdat);
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		m_cyc_i = 1'b0;
		m_stb_i = 1'b0;
		m_we_i = 1'b0;
		m_adr_i = '0;
		m_sel_i = '0;
		m_dat_i = '0;
		seed = 20217;
		build_table();
		// Two reset cycles
		repeat (2) @(posedge clk);
		rstn <= 1'b1;
		// Quiet bus after reset
		repeat (4) begin
			@(negedge clk);
			check_flag("m_ack_o", 1'b0, m_ack_o);
			check_flag("m_err_o", 1'b0, m_err_o);
		end
		foreach (table_q[i]) begin
			apply_row(table_q[i], i);
		end
		random_pass();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+include
hw/wb_pkg.sv
hw/wb_req_decoder.sv
hw/wb_ram_target.sv
hw/wb_resp_mux.sv
hw/wb_subsys_top.sv
testbench/tb_wb_subsys.sv
